// File: compute_socket.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/dcr_pkg.sv
hdl/mem_arb.sv
hdl/socket_relay.sv
hdl/kernel_core.sv
hdl/compute_socket.sv
verif/compute_socket_tb.sv

// File: hdl/compute_socket.sv
// Compute socket top level: DCR/busy relay, the kernel cores and the memory arbiter.
// Only instances and the wires between them live here.

`timescale 1ns/1ns

`include "socket_config.svh"

module compute_socket (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dcr_wr_valid,
    input  dcr_pkg::dcr_write_t   dcr_wr,
    output logic                  mem_req_valid,
    output mem_bus_pkg::mem_req_t mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t mem_rsp,
    output logic                  busy
);

    logic                                      core_dcr_valid;
    dcr_pkg::dcr_write_t                       core_dcr;
    logic [`SOCKET_SIZE-1:0]                   core_busy;
    logic [`SOCKET_SIZE-1:0]                   core_req_valid;
    logic [`SOCKET_SIZE-1:0]                   core_req_ready;
    mem_bus_pkg::core_req_t [`SOCKET_SIZE-1:0] core_req;
    logic [`SOCKET_SIZE-1:0]                   core_rsp_valid;
    mem_bus_pkg::core_rsp_t                    core_rsp;

    // broadcast config in, busy out
    socket_relay relay (
        .clk            (clk),
        .rst_n          (rst_n),
        .dcr_wr_valid   (dcr_wr_valid),
        .dcr_wr         (dcr_wr),
        .core_dcr_valid (core_dcr_valid),
        .core_dcr       (core_dcr),
        .core_busy      (core_busy),
        .busy           (busy)
    );

    for (genvar i = 0; i < `SOCKET_SIZE; i++) begin : g_core
        kernel_core #(
            .CORE_ID (i)
        ) core (
            .clk       (clk),
            .rst_n     (rst_n),
            .dcr_valid (core_dcr_valid),
            .dcr       (core_dcr),
            .req_valid (core_req_valid[i]),
            .req       (core_req[i]),
            .req_ready (core_req_ready[i]),
            .rsp_valid (core_rsp_valid[i]),
            .rsp       (core_rsp),
            .busy      (core_busy[i])
        );
    end

    // all cores share one memory port
    mem_arb arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp)
    );

endmodule

// File: hdl/dcr_pkg.sv
// Device configuration register types for the DCR write bus.
// The relay broadcasts writes of this shape to every core.

package dcr_pkg;

    // register map of one kernel core
    typedef enum logic [1:0] {
        DCR_SRC_BASE = 2'd0,
        DCR_DST_BASE = 2'd1,
        DCR_COUNT    = 2'd2,
        DCR_START    = 2'd3
    } dcr_addr_e;

    // DCR payload
    // bases and count use the low address bits only
    typedef logic [31:0] dcr_data_t;

    // one write on the bus
    typedef struct packed {
        dcr_addr_e addr;
        dcr_data_t data;
    } dcr_write_t;

endpackage

// File: hdl/kernel_core.sv
// One compute core running the fixed kernel dst[i] = src[i] + CORE_ID + 1.
// Configured over DCR, launched by DCR_START, works on its own slice of words.

`timescale 1ns/1ns

`include "socket_config.svh"

module kernel_core #(
    parameter int CORE_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dcr_valid,
    input  dcr_pkg::dcr_write_t    dcr,
    output logic                   req_valid,
    output mem_bus_pkg::core_req_t req,
    input  logic                   req_ready,
    input  logic                   rsp_valid,
    input  mem_bus_pkg::core_rsp_t rsp,
    output logic                   busy
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT,
        WRITE
    } state_e;

    localparam mem_bus_pkg::data_t ADDEND = mem_bus_pkg::data_t'(CORE_ID + 1);

    state_e             state;
    mem_bus_pkg::addr_t src_base;
    mem_bus_pkg::addr_t dst_base;
    mem_bus_pkg::addr_t count;
    mem_bus_pkg::addr_t idx;
    mem_bus_pkg::addr_t slice_off;
    mem_bus_pkg::data_t wr_data;
    logic               start_hit;
    logic               rsp_hit;
    logic               last;

    //////////////////////////////////////////////////
    // DCR register file

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_base <= '0;
            dst_base <= '0;
            count    <= '0;
        end else if (dcr_valid) begin
            case (dcr.addr)
                dcr_pkg::DCR_SRC_BASE: src_base <= dcr.data[`ADDR_WIDTH-1:0];
                dcr_pkg::DCR_DST_BASE: dst_base <= dcr.data[`ADDR_WIDTH-1:0];
                dcr_pkg::DCR_COUNT:    count    <= dcr.data[`ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // launch only from idle
    assign start_hit = dcr_valid && (dcr.addr == dcr_pkg::DCR_START) && (state == IDLE);

    //////////////////////////////////////////////////
    // load / add / store loop

    // each core owns count words starting at CORE_ID * count
    assign slice_off = mem_bus_pkg::addr_t'(CORE_ID) * count;
    assign last      = (idx == count - 1'b1);
    assign rsp_hit   = rsp_valid && (rsp.tag == idx[`CORE_TAG_WIDTH-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_hit) begin
                        idx   <= '0;
                        state <= READ;
                    end
                end
                READ: begin
                    // only reached with idx == count when count is zero
                    if (idx == count) begin
                        state <= IDLE;
                    end else if (req_ready) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (rsp_hit) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (req_ready) begin
                        if (last) begin
                            state <= IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // result of the add, held until the store goes out
    always_ff @(posedge clk) begin
        if (state == WAIT && rsp_hit) begin
            wr_data <= rsp.data + ADDEND;
        end
    end

    //////////////////////////////////////////////////
    // request port

    assign req_valid = ((state == READ) && (idx != count)) || (state == WRITE);

    always_comb begin
        req.write = (state == WRITE);
        req.addr  = ((state == WRITE) ? dst_base : src_base) + slice_off + idx;
        req.data  = (state == WRITE) ? wr_data : '0;
        req.tag   = idx[`CORE_TAG_WIDTH-1:0];
    end

    assign busy = (state != IDLE);

endmodule

// File: hdl/mem_arb.sv
// Round-robin arbiter that merges the core request ports onto one memory port.
// Core index goes into the upper tag bits; responses are steered back by tag.

`timescale 1ns/1ns

`include "socket_config.svh"

module mem_arb (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [`SOCKET_SIZE-1:0]                   core_req_valid,
    input  mem_bus_pkg::core_req_t [`SOCKET_SIZE-1:0] core_req,
    output logic [`SOCKET_SIZE-1:0]                   core_req_ready,
    output logic                                      mem_req_valid,
    output mem_bus_pkg::mem_req_t                     mem_req,
    input  logic                                      mem_req_ready,
    input  logic                                      mem_rsp_valid,
    input  mem_bus_pkg::mem_rsp_t                     mem_rsp,
    output logic [`SOCKET_SIZE-1:0]                   core_rsp_valid,
    output mem_bus_pkg::core_rsp_t                    core_rsp
);

    // core that goes first in the next arbitration
    logic [`CORE_SEL_BITS-1:0] rr_ptr;
    logic [`CORE_SEL_BITS-1:0] grant_idx;
    logic [`CORE_SEL_BITS-1:0] next_ptr;
    // grant frozen while the memory side stalls
    logic                      hold;
    logic [`CORE_SEL_BITS-1:0] hold_idx;
    logic [`CORE_SEL_BITS-1:0] rsp_sel;

    //////////////////////////////////////////////////
    // request side

    always_comb begin
        int unsigned idx;
        logic        found;
        grant_idx = hold_idx;
        found     = hold;
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            idx = (int'(rr_ptr) + i) % `SOCKET_SIZE;
            if (!found && core_req_valid[idx]) begin
                grant_idx = idx[`CORE_SEL_BITS-1:0];
                found     = 1'b1;
            end
        end
    end

    assign mem_req_valid = core_req_valid[grant_idx];

    always_comb begin
        mem_req.write = core_req[grant_idx].write;
        mem_req.addr  = core_req[grant_idx].addr;
        mem_req.data  = core_req[grant_idx].data;
        mem_req.tag   = {grant_idx, core_req[grant_idx].tag};
    end

    // only the granted core sees ready, and only when memory takes it
    always_comb begin
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            core_req_ready[i] = mem_req_ready && (grant_idx == i);
        end
    end

    assign next_ptr = (grant_idx == `SOCKET_SIZE - 1) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr   <= '0;
            hold     <= 1'b0;
            hold_idx <= '0;
        end else if (mem_req_valid && mem_req_ready) begin
            rr_ptr <= next_ptr;
            hold   <= 1'b0;
        end else if (mem_req_valid) begin
            // stalled, keep this core on the port
            hold     <= 1'b1;
            hold_idx <= grant_idx;
        end
    end

    //////////////////////////////////////////////////
    // response side

    assign rsp_sel = mem_rsp.tag[`CORE_TAG_WIDTH +: `CORE_SEL_BITS];

    always_comb begin
        for (int i = 0; i < `SOCKET_SIZE; i++) begin
            core_rsp_valid[i] = mem_rsp_valid && (rsp_sel == i);
        end
    end

    // payload is shared, the valid picks the core
    assign core_rsp.data = mem_rsp.data;
    assign core_rsp.tag  = mem_rsp.tag[`CORE_TAG_WIDTH-1:0];

endmodule

// File: hdl/mem_bus_pkg.sv
// Memory bus types for the core side and the socket side of the arbiter.
// Referenced by scoped name from the cores, the arbiter and the top level.

`include "socket_config.svh"

package mem_bus_pkg;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // tag as issued by a core
    typedef logic [`CORE_TAG_WIDTH-1:0] core_tag_t;

    // socket tag, core index on top of the core tag
    typedef logic [`CORE_SEL_BITS+`CORE_TAG_WIDTH-1:0] mem_tag_t;

    // core side
    typedef struct packed {
        logic      write;
        addr_t     addr;
        data_t     data;
        core_tag_t tag;
    } core_req_t;

    typedef struct packed {
        data_t     data;
        core_tag_t tag;
    } core_rsp_t;

    // socket side
    typedef struct packed {
        logic     write;
        addr_t    addr;
        data_t    data;
        mem_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        data_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

endpackage

// File: hdl/socket_config.svh
// Socket-wide sizing macros shared by the packages and the RTL.
// Include wherever a width or the core count is needed.

`ifndef SOCKET_CONFIG_SVH
`define SOCKET_CONFIG_SVH

// number of compute cores in the socket
`define SOCKET_SIZE 2

// word address width on the memory port
`define ADDR_WIDTH 16

// data word width
`define DATA_WIDTH 32

// tag bits generated by one core
`define CORE_TAG_WIDTH 4

// tag bits the arbiter prepends to select the core
// log2 of SOCKET_SIZE, never below 1
`define CORE_SEL_BITS 1

`endif

// File: hdl/socket_relay.sv
// Buffer stage between the socket ports and the cores.
// Registers the broadcast DCR write and the OR of the core busy flags.

`timescale 1ns/1ns

`include "socket_config.svh"

module socket_relay (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dcr_wr_valid,
    input  dcr_pkg::dcr_write_t     dcr_wr,
    output logic                    core_dcr_valid,
    output dcr_pkg::dcr_write_t     core_dcr,
    input  logic [`SOCKET_SIZE-1:0] core_busy,
    output logic                    busy
);

    // strobe and status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_dcr_valid <= 1'b0;
            busy           <= 1'b0;
        end else begin
            core_dcr_valid <= dcr_wr_valid;
            busy           <= |core_busy;
        end
    end

    // payload only moves with a write
    always_ff @(posedge clk) begin
        if (dcr_wr_valid) begin
            core_dcr <= dcr_wr;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the compute socket testbench with Verilator and run it.
# Exit status is zero only when the pass line appears in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
    --top-module compute_socket_tb \
    -f compute_socket.f

output=$(./obj_dir/Vcompute_socket_tb)
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
fi
exit 1

// File: verif/compute_socket_tb.sv
// Testbench for the compute socket: memory model with stalls and out-of-order
// responses, a table of kernel runs applied in a loop, result and protocol checks.
// Top module compute_socket_tb, run through the file list in the project root.

`timescale 1ns/1ns

`include "socket_config.svh"

module compute_socket_tb;

    typedef struct packed {
        int unsigned src;
        int unsigned dst;
        int unsigned count;
        int unsigned stall_pct;
        int unsigned exp_writes;
    } row_t;

    // read waiting for its response
    typedef struct packed {
        mem_bus_pkg::mem_tag_t tag;
        mem_bus_pkg::data_t    data;
        int unsigned           due;
    } pend_t;

    localparam int NUM_TESTS = 5;

    // src, dst, count, stall percent, expected writes
    localparam row_t TESTS [NUM_TESTS] = '{
        '{32'h0100, 32'h0800,  4,  0,  8},
        '{32'h0200, 32'h0900,  8, 70, 16},
        '{32'h0300, 32'h0a00,  0, 30,  0},
        '{32'h0400, 32'h0b00, 16, 35, 32},
        '{32'h0b10, 32'h0c00, 12, 20, 24}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  dcr_wr_valid;
    dcr_pkg::dcr_write_t   dcr_wr;
    logic                  mem_req_valid;
    mem_bus_pkg::mem_req_t mem_req;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    mem_bus_pkg::mem_rsp_t mem_rsp;
    logic                  busy;

    mem_bus_pkg::data_t    mem [0:65535];
    mem_bus_pkg::data_t    exp_mem [int unsigned];
    int unsigned           rd_count [int unsigned];
    pend_t                 pend_q [$];
    int unsigned           cyc;
    int unsigned           cur_stall;
    int unsigned           src_lo;
    int unsigned           src_hi;
    int unsigned           dst_lo;
    int unsigned           dst_hi;
    int unsigned           wr_count;
    int unsigned           req_seen;
    int                    errors;
    int                    failed;
    logic                  stalled_prev;
    mem_bus_pkg::mem_req_t prev_req;

    compute_socket DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr        (dcr_wr),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned watchdog_cycles();
        int unsigned total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += TESTS[t].count;
        end
        return total * `SOCKET_SIZE * 20 + 200;
    endfunction

    //////////////////////////////////////////////////
    // memory model

    // ready pattern and one response strobe per cycle
    initial begin : mem_drive
        int sel;
        forever begin
            @(posedge clk);
            #2;
            cyc++;
            mem_req_ready = (($urandom % 100) >= cur_stall);
            sel = -1;
            foreach (pend_q[j]) begin
                if (sel < 0 && pend_q[j].due <= cyc) begin
                    sel = j;
                end
            end
            if (sel >= 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp.data  = pend_q[sel].data;
                mem_rsp.tag   = pend_q[sel].tag;
                pend_q.delete(sel);
            end else begin
                mem_rsp_valid = 1'b0;
            end
        end
    end

    task automatic accept_request();
        int unsigned a;
        pend_t       p;
        a = 32'(mem_req.addr);
        req_seen++;
        if (mem_req.write) begin
            if (a < dst_lo || a >= dst_hi) begin
                $display("write to address %h lies outside the destination range", a);
                errors++;
            end
            mem[mem_req.addr] = mem_req.data;
            wr_count++;
        end else begin
            if (a < src_lo || a >= src_hi) begin
                $display("read of address %h lies outside the source range", a);
                errors++;
            end
            rd_count[a] = rd_count.exists(a) ? rd_count[a] + 1 : 1;
            p.tag  = mem_req.tag;
            p.data = mem[mem_req.addr];
            p.due  = cyc + 1 + ($urandom % 4);
            pend_q.push_back(p);
        end
    endtask

    // mid-cycle sampling, values here are what the next edge transfers
    always @(negedge clk) begin
        if (rst_n) begin
            if (stalled_prev && !mem_req_valid) begin
                $display("** Error: mem_req_valid got %h exp %h under stall", mem_req_valid, 1'b1);
                errors++;
            end else if (stalled_prev && mem_req !== prev_req) begin
                $display("** Error: mem_req got %h exp %h under stall", mem_req, prev_req);
                errors++;
            end
            if (mem_req_valid && mem_req_ready) begin
                accept_request();
            end
            stalled_prev = mem_req_valid && !mem_req_ready;
            prev_req     = mem_req;
        end
    end

    //////////////////////////////////////////////////
    // test sequence

    task automatic write_dcr(input dcr_pkg::dcr_addr_e addr, input dcr_pkg::dcr_data_t data);
        @(posedge clk);
        #2;
        dcr_wr_valid = 1'b1;
        dcr_wr.addr  = addr;
        dcr_wr.data  = data;
        @(posedge clk);
        #2;
        dcr_wr_valid = 1'b0;
    endtask

    task automatic run_test(input int t);
        row_t        r;
        int          start_err;
        int unsigned a;
        r = TESTS[t];
        start_err = errors;
        cur_stall = r.stall_pct;
        wr_count  = 0;
        req_seen  = 0;
        rd_count.delete();
        exp_mem.delete();
        src_lo = r.src;
        src_hi = r.src + `SOCKET_SIZE * r.count;
        dst_lo = r.dst;
        dst_hi = r.dst + `SOCKET_SIZE * r.count;
        // core k adds k+1 to its own slice
        for (int unsigned k = 0; k < `SOCKET_SIZE; k++) begin
            for (int unsigned i = 0; i < r.count; i++) begin
                a = r.src + k * r.count + i;
                exp_mem[r.dst + k * r.count + i] = mem[a[15:0]] + (k + 1);
            end
        end
        write_dcr(dcr_pkg::DCR_SRC_BASE, r.src);
        write_dcr(dcr_pkg::DCR_DST_BASE, r.dst);
        write_dcr(dcr_pkg::DCR_COUNT, r.count);
        write_dcr(dcr_pkg::DCR_START, 32'd0);
        // busy rises on the second edge after the one that captures the start
        repeat (2) @(negedge clk);
        if (busy !== 1'b0) begin
            $display("** Error: busy got %h exp %h one cycle early", busy, 1'b0);
            errors++;
        end
        @(negedge clk);
        if (r.count != 0 && busy !== 1'b1) begin
            $display("** Error: busy got %h exp %h after start", busy, 1'b1);
            errors++;
        end
        while (busy) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        foreach (exp_mem[d]) begin
            if (mem[d[15:0]] !== exp_mem[d]) begin
                $display("** Error: mem[%h] got %h exp %h", d, mem[d[15:0]], exp_mem[d]);
                errors++;
            end
        end
        for (a = src_lo; a < src_hi; a++) begin
            if (!rd_count.exists(a) || rd_count[a] != 1) begin
                $display("source word %h was not read exactly once", a);
                errors++;
            end
        end
        if (wr_count != r.exp_writes) begin
            $display("** Error: write count got %h exp %h", wr_count, r.exp_writes);
            errors++;
        end
        if (req_seen != 2 * r.exp_writes) begin
            $display("** Error: request count got %h exp %h", req_seen, 2 * r.exp_writes);
            errors++;
        end
        if (errors != start_err) begin
            failed++;
        end
        $display("test %0d: count %0d, %0d writes, %0d errors",
                 t, r.count, wr_count, errors - start_err);
    endtask

    initial begin : main
        rst_n         = 1'b0;
        dcr_wr_valid  = 1'b0;
        dcr_wr        = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        cyc           = 0;
        cur_stall     = 0;
        errors        = 0;
        failed        = 0;
        stalled_prev  = 1'b0;
        void'($urandom(32'h708b_a7c4));
        for (int a = 0; a < 65536; a++) begin
            mem[a] = $urandom ^ {a[15:0], a[15:0]};
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (mem_req_valid !== 1'b0 || busy !== 1'b0) begin
            $display("** Error: mem_req_valid/busy got %h/%h exp 0/0 after reset",
                     mem_req_valid, busy);
            errors++;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // bound on the whole run, scaled by the work in the table
    initial begin : watchdog
        int unsigned limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk);
        $display("timeout: the socket did not finish within %0d clock cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule
